/* logic/csr_pkg.sv */
// shared types and constants for the machine-mode CSR block
// covers CSR indices and addresses, reset values, SYSTEM encodings,
// the instruction word union and the structs passed between stages
// every file refers to these by scoped names

package csr_pkg;

    typedef logic [1:0] csr_idx_t;  // one of the four implemented CSRs

    localparam csr_idx_t idx_mstatus = 2'd0;
    localparam csr_idx_t idx_mtvec   = 2'd1;
    localparam csr_idx_t idx_mepc    = 2'd2;
    localparam csr_idx_t idx_mcause  = 2'd3;

    localparam logic [11:0] addr_mstatus = 12'h300;
    localparam logic [11:0] addr_mtvec   = 12'h305;
    localparam logic [11:0] addr_mepc    = 12'h341;
    localparam logic [11:0] addr_mcause  = 12'h342;

    localparam logic [31:0] rst_mstatus   = 32'h0000_1800;  // MPP = machine
    localparam logic [31:0] rst_mcause    = 32'h0000_000b;
    localparam logic [31:0] cause_ecall_m = 32'd11;

    localparam logic [6:0]  opcode_system = 7'b1110011;
    localparam logic [11:0] funct12_ecall = 12'h000;
    localparam logic [11:0] funct12_mret  = 12'h302;

    typedef enum logic [1:0] {
        op_rw,
        op_rs,
        op_rc
    } csr_op_t;

    // word seen as a Zicsr instruction
    typedef struct packed {
        logic [11:0] csr_addr;
        logic [4:0]  rs1_zimm;  // rs1 or 5-bit immediate
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_fields_t;

    // same word seen as ecall / mret
    typedef struct packed {
        logic [11:0] funct12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } sys_fields_t;

    typedef union packed {
        csr_fields_t csr_fields;
        sys_fields_t sys_fields;
    } inst_u;

    typedef struct packed {
        logic       valid;
        csr_op_t    op;
        csr_idx_t   idx;
        logic       use_imm;
        logic [4:0] zimm;
        logic       src_is_zero;  // rs1 = x0 or zimm = 0
    } csr_req_t;

    typedef struct packed {
        logic ecall;
        logic mret;
    } sys_req_t;

    typedef struct packed {
        logic        take;
        logic [31:0] epc;
    } trap_wr_t;

endpackage

/* logic/csr_decode.sv */
// decode of one SYSTEM instruction per cycle
// funct3 = 0 selects ecall / mret, any other funct3 is a CSR access
// unknown address, funct3 or funct12 raises illegal_inst and drops
// both requests, words with another opcode are not for this block

module csr_decode (
    input  csr_pkg::inst_u    inst,
    input  logic              inst_valid,
    output csr_pkg::csr_req_t csr_req,
    output csr_pkg::sys_req_t sys_req,
    output logic              illegal_inst
);

    logic              is_system;
    logic              is_sys_form;
    logic              addr_ok;
    logic              funct3_ok;
    csr_pkg::csr_idx_t idx;
    csr_pkg::csr_op_t  op;

    assign is_system   = inst_valid && (inst.csr_fields.opcode == csr_pkg::opcode_system);
    assign is_sys_form = (inst.sys_fields.funct3 == 3'b000);

    // address to register index
    always_comb begin
        addr_ok = 1'b1;
        idx     = csr_pkg::idx_mstatus;
        case (inst.csr_fields.csr_addr)
            csr_pkg::addr_mstatus: idx = csr_pkg::idx_mstatus;
            csr_pkg::addr_mtvec:   idx = csr_pkg::idx_mtvec;
            csr_pkg::addr_mepc:    idx = csr_pkg::idx_mepc;
            csr_pkg::addr_mcause:  idx = csr_pkg::idx_mcause;
            default:               addr_ok = 1'b0;
        endcase
    end

    // funct3[1:0] picks the op, funct3[2] the immediate form
    always_comb begin
        funct3_ok = 1'b1;
        op        = csr_pkg::op_rw;
        case (inst.csr_fields.funct3[1:0])
            2'b01:   op = csr_pkg::op_rw;
            2'b10:   op = csr_pkg::op_rs;
            2'b11:   op = csr_pkg::op_rc;
            default: funct3_ok = 1'b0;  // 3'b100 is reserved
        endcase
    end

    always_comb begin
        csr_req      = '0;
        sys_req      = '0;
        illegal_inst = 1'b0;
        if (is_system) begin
            if (is_sys_form) begin
                case (inst.sys_fields.funct12)
                    csr_pkg::funct12_ecall: sys_req.ecall = 1'b1;
                    csr_pkg::funct12_mret:  sys_req.mret  = 1'b1;
                    default:                illegal_inst  = 1'b1;
                endcase
            end else if (addr_ok && funct3_ok) begin
                csr_req.valid       = 1'b1;
                csr_req.op          = op;
                csr_req.idx         = idx;
                csr_req.use_imm     = inst.csr_fields.funct3[2];
                csr_req.zimm        = inst.csr_fields.rs1_zimm;
                csr_req.src_is_zero = (inst.csr_fields.rs1_zimm == 5'd0);
            end else begin
                illegal_inst = 1'b1;
            end
        end
    end

endmodule

/* logic/csr_op_unit.sv */
// new CSR value for csrrw / csrrs / csrrc and the immediate forms
// purely combinational, read_data is the current value of the target
// set and clear with a zero source leave the register alone

module csr_op_unit (
    input  csr_pkg::csr_req_t csr_req,
    input  logic [31:0]       rs1_data,
    input  logic [31:0]       read_data,
    output logic [31:0]       wr_data,
    output logic              wr_en
);

    logic [31:0] src;
    logic        is_rw;

    // zimm is zero-extended
    assign src   = csr_req.use_imm ? {27'd0, csr_req.zimm} : rs1_data;
    assign is_rw = (csr_req.op == csr_pkg::op_rw);

    always_comb begin
        case (csr_req.op)
            csr_pkg::op_rw: wr_data = src;
            csr_pkg::op_rs: wr_data = read_data | src;
            csr_pkg::op_rc: wr_data = read_data & ~src;
            default:        wr_data = read_data;
        endcase
    end

    // csrrw always writes, even with x0
    assign wr_en = csr_req.valid && (is_rw || !csr_req.src_is_zero);

endmodule

/* logic/csr_file.sv */
// storage for mstatus, mtvec, mepc and mcause
// reads are combinational through an AND-OR mux, writes land at the
// next rising clk; the trap path loads mepc and mcause on ecall
// mtvec and mepc are also exported for the trap unit

module csr_file (
    input  logic              clk,
    input  logic              rst,
    input  csr_pkg::csr_req_t csr_req,
    input  logic [31:0]       wr_data,
    input  logic              wr_en,
    input  csr_pkg::trap_wr_t trap_wr,
    output logic [31:0]       read_data,
    output logic [31:0]       mtvec,
    output logic [31:0]       mepc
);

    logic [31:0] csr_reg [4];
    logic [3:0]  w_e;         // one-hot write select
    logic [3:0]  r_e;         // one-hot read select

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            w_e[i] = wr_en && (csr_req.idx == i[1:0]);
            r_e[i] = csr_req.valid && (csr_req.idx == i[1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_reg[csr_pkg::idx_mstatus] <= csr_pkg::rst_mstatus;
            csr_reg[csr_pkg::idx_mtvec]   <= 32'd0;
            csr_reg[csr_pkg::idx_mepc]    <= 32'd0;
            csr_reg[csr_pkg::idx_mcause]  <= csr_pkg::rst_mcause;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (w_e[i]) begin
                    csr_reg[i] <= wr_data;
                end
            end
            // ecall and a CSR write never share a cycle
            if (trap_wr.take) begin
                csr_reg[csr_pkg::idx_mepc]   <= trap_wr.epc;
                csr_reg[csr_pkg::idx_mcause] <= csr_pkg::cause_ecall_m;
            end
        end
    end

    // AND-OR read, zero when no CSR access is active
    always_comb begin
        read_data = 32'd0;
        for (int i = 0; i < 4; i++) begin
            read_data = read_data | ({32{r_e[i]}} & csr_reg[i]);
        end
    end

    assign mtvec = csr_reg[csr_pkg::idx_mtvec];
    assign mepc  = csr_reg[csr_pkg::idx_mepc];

endmodule

/* logic/trap_unit.sv */
// trap entry on ecall and return on mret
// ecall saves pc as the epc and jumps to the mtvec base,
// mret jumps back to mepc; no state of its own

module trap_unit (
    input  csr_pkg::sys_req_t sys_req,
    input  logic [31:0]       pc,
    input  logic [31:0]       mtvec,
    input  logic [31:0]       mepc,
    output csr_pkg::trap_wr_t trap_wr,
    output logic              redirect_valid,
    output logic [31:0]       redirect_pc
);

    logic [31:0] trap_base;

    // direct mode only, mode bits dropped
    assign trap_base = {mtvec[31:2], 2'b00};

    assign trap_wr.take = sys_req.ecall;
    assign trap_wr.epc  = pc;

    assign redirect_valid = sys_req.ecall || sys_req.mret;

    always_comb begin
        if (sys_req.ecall) begin
            redirect_pc = trap_base;
        end else if (sys_req.mret) begin
            redirect_pc = mepc;
        end else begin
            redirect_pc = 32'd0;  // quiet when idle
        end
    end

endmodule

/* logic/csr_unit_top.sv */
// machine-mode CSR block of the RV32E core
// takes one decoded SYSTEM instruction per cycle from decode, with no
// stalls; returns the old CSR value for rd and the redirect for
// ecall / mret, all outputs combinational in the same cycle
// CSR and trap writes are visible from the next cycle on

module csr_unit_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           inst_valid,
    input  csr_pkg::inst_u inst,
    input  logic [31:0]    rs1_data,
    input  logic [31:0]    pc,
    output logic [31:0]    rd_data,
    output logic           rd_we,
    output logic           redirect_valid,
    output logic [31:0]    redirect_pc,
    output logic           illegal_inst
);

    csr_pkg::csr_req_t csr_req;
    csr_pkg::sys_req_t sys_req;
    csr_pkg::trap_wr_t trap_wr;
    logic [31:0]       read_data;
    logic [31:0]       wr_data;
    logic              wr_en;
    logic [31:0]       mtvec;
    logic [31:0]       mepc;

    csr_decode csr_decode_inst (
        .inst         (inst),
        .inst_valid   (inst_valid),
        .csr_req      (csr_req),
        .sys_req      (sys_req),
        .illegal_inst (illegal_inst)
    );

    csr_op_unit csr_op_unit_inst (
        .csr_req   (csr_req),
        .rs1_data  (rs1_data),
        .read_data (read_data),
        .wr_data   (wr_data),
        .wr_en     (wr_en)
    );

    csr_file csr_file_inst (
        .clk       (clk),
        .rst       (rst),
        .csr_req   (csr_req),
        .wr_data   (wr_data),
        .wr_en     (wr_en),
        .trap_wr   (trap_wr),
        .read_data (read_data),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

    trap_unit trap_unit_inst (
        .sys_req        (sys_req),
        .pc             (pc),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .trap_wr        (trap_wr),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    assign rd_data = read_data;      // old value, before this write
    assign rd_we   = csr_req.valid;

endmodule

/* testbench/csr_unit_tb.sv */
// testbench for the machine-mode CSR block
// applies a table of instructions with expected outputs, one per cycle,
// then a random csrrw phase on mtvec / mepc against a shadow model
// inputs change on the falling edge, outputs are checked mid-cycle

module csr_unit_tb;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        logic [31:0] rs1_data;
        logic [31:0] pc;
        logic [31:0] exp_rd_data;
        logic        exp_rd_we;
        logic        exp_redirect_valid;
        logic [31:0] exp_redirect_pc;
        logic        exp_illegal;
    } entry_t;

    localparam logic [2:0] f3_rw  = 3'b001;
    localparam logic [2:0] f3_rs  = 3'b010;
    localparam logic [2:0] f3_rc  = 3'b011;
    localparam logic [2:0] f3_rwi = 3'b101;
    localparam logic [2:0] f3_rsi = 3'b110;
    localparam logic [2:0] f3_rci = 3'b111;

    logic           clk;
    logic           rst;
    logic           inst_valid;
    csr_pkg::inst_u inst;
    logic [31:0]    rs1_data;
    logic [31:0]    pc;
    logic [31:0]    rd_data;
    logic           rd_we;
    logic           redirect_valid;
    logic [31:0]    redirect_pc;
    logic           illegal_inst;

    entry_t      stim_table[$];
    logic [31:0] lfsr_state;
    logic [31:0] shadow_mtvec;
    logic [31:0] shadow_mepc;

    csr_unit_top csr_unit_top_inst (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .rs1_data       (rs1_data),
        .pc             (pc),
        .rd_data        (rd_data),
        .rd_we          (rd_we),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .illegal_inst   (illegal_inst)
    );

    always #2 clk = ~clk;

    // Zicsr word with rd fixed at x1
    function automatic logic [31:0] csr_word(input logic [11:0] addr,
                                             input logic [4:0] src,
                                             input logic [2:0] funct3);
        csr_word = {addr, src, funct3, 5'd1, 7'b1110011};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        lfsr_next = state >> 1;
        if (state[0]) begin
            lfsr_next = lfsr_next ^ 32'ha300_0000;  // galois taps
        end
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = 32'd0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic wait_drive_edge();
        int spins;
        spins = 0;
        do begin
            @(clk);
            spins++;
        end while (clk !== 1'b0 && spins < 4);
        if (clk !== 1'b0) begin
            $display("clock did not fall within two periods");
            $display("TESTBENCH FAILED");
            $fatal(1, "clock stalled");
        end
    endtask

    task automatic add_entry(input logic valid, input logic [31:0] word,
                             input logic [31:0] src, input logic [31:0] at_pc,
                             input logic [31:0] rd, input logic we, input logic rv,
                             input logic [31:0] rpc, input logic ill);
        stim_table.push_back({valid, word, src, at_pc, rd, we, rv, rpc, ill});
    endtask

    // legal CSR access that returns the old value
    task automatic add_csr(input logic [11:0] addr, input logic [4:0] src,
                           input logic [2:0] funct3, input logic [31:0] data,
                           input logic [31:0] old_value);
        add_entry(1'b1, csr_word(addr, src, funct3), data, 32'h0, old_value,
                  1'b1, 1'b0, 32'h0, 1'b0);
    endtask

    task automatic apply_entry(input entry_t e);
        wait_drive_edge();
        inst_valid = e.valid;
        inst       = e.inst;
        rs1_data   = e.rs1_data;
        pc         = e.pc;
        #1;
        check_value("rd_data", rd_data, e.exp_rd_data);
        check_value("rd_we", 32'(rd_we), 32'(e.exp_rd_we));
        check_value("redirect_valid", 32'(redirect_valid), 32'(e.exp_redirect_valid));
        check_value("redirect_pc", redirect_pc, e.exp_redirect_pc);
        check_value("illegal_inst", 32'(illegal_inst), 32'(e.exp_illegal));
    endtask

    initial begin
        entry_t      e;
        logic [31:0] pick;
        logic [31:0] data;
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        rs1_data   = 32'd0;
        pc         = 32'd0;
        lfsr_state = 32'he6d;

        // reset values, and a read with x0 disturbs nothing
        add_csr(12'h300, 5'd0, f3_rs, 32'h0, 32'h0000_1800);
        add_csr(12'h305, 5'd0, f3_rs, 32'h0, 32'h0);
        add_csr(12'h341, 5'd0, f3_rs, 32'h0, 32'h0);
        add_csr(12'h342, 5'd0, f3_rs, 32'h0, 32'h0000_000b);
        add_csr(12'h300, 5'd0, f3_rs, 32'h0, 32'h0000_1800);
        // register forms on mtvec step through 0x1003 and 0x1f03 and back
        add_csr(12'h305, 5'd5, f3_rw, 32'h0000_1003, 32'h0);
        add_csr(12'h305, 5'd5, f3_rs, 32'h0000_0f00, 32'h0000_1003);
        add_csr(12'h305, 5'd5, f3_rc, 32'h0000_0f00, 32'h0000_1f03);
        // immediate forms on mepc give 0x15 then 0x1f then 0x1c
        add_csr(12'h341, 5'h15, f3_rwi, 32'hffff_ffff, 32'h0);
        add_csr(12'h341, 5'h0a, f3_rsi, 32'hffff_ffff, 32'h0000_0015);
        add_csr(12'h341, 5'h03, f3_rci, 32'hffff_ffff, 32'h0000_001f);
        // set and clear with a zero source skip the write and rw writes zero
        add_csr(12'h341, 5'd0, f3_rs, 32'hffff_ffff, 32'h0000_001c);
        add_csr(12'h341, 5'd0, f3_rc, 32'hffff_ffff, 32'h0000_001c);
        add_csr(12'h341, 5'd0, f3_rsi, 32'h0, 32'h0000_001c);
        add_csr(12'h341, 5'd0, f3_rs, 32'h0, 32'h0000_001c);
        add_csr(12'h342, 5'd0, f3_rw, 32'h0, 32'h0000_000b);
        add_csr(12'h342, 5'd0, f3_rs, 32'h0, 32'h0);
        // ecall at 0x400 jumps to mtvec base 0x1000 and mret comes back
        add_entry(1'b1, 32'h0000_0073, 32'h0, 32'h400, 32'h0, 1'b0, 1'b1, 32'h1000, 1'b0);
        add_csr(12'h341, 5'd0, f3_rs, 32'h0, 32'h0000_0400);
        add_csr(12'h342, 5'd0, f3_rs, 32'h0, 32'h0000_000b);
        add_entry(1'b1, 32'h3020_0073, 32'h0, 32'h1000, 32'h0, 1'b0, 1'b1, 32'h400, 1'b0);
        // illegal address 0x7c0 and funct3 100 and wfi as funct12
        add_entry(1'b1, csr_word(12'h7c0, 5'd5, f3_rw), 32'h1234, 32'h0,
                  32'h0, 1'b0, 1'b0, 32'h0, 1'b1);
        add_entry(1'b1, csr_word(12'h305, 5'd5, 3'b100), 32'h1234, 32'h0,
                  32'h0, 1'b0, 1'b0, 32'h0, 1'b1);
        add_entry(1'b1, 32'h1050_0073, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 32'h0, 1'b1);
        add_csr(12'h300, 5'd0, f3_rs, 32'h0, 32'h0000_1800);
        add_csr(12'h305, 5'd0, f3_rs, 32'h0, 32'h0000_1003);
        add_csr(12'h341, 5'd0, f3_rs, 32'h0, 32'h0000_0400);
        // with valid low everything is quiet and nothing is written
        add_entry(1'b0, csr_word(12'h305, 5'd5, f3_rw), 32'hffff_ffff, 32'h400,
                  32'h0, 1'b0, 1'b0, 32'h0, 1'b0);
        add_csr(12'h305, 5'd0, f3_rs, 32'h0, 32'h0000_1003);

        for (int n = 0; n < 16; n++) begin
            @(posedge clk);
        end
        wait_drive_edge();
        rst = 1'b0;

        foreach (stim_table[i]) begin
            apply_entry(stim_table[i]);
        end

        shadow_mtvec = 32'h0000_1003;
        shadow_mepc  = 32'h0000_0400;
        for (int n = 0; n < 32; n++) begin
            random_bits(1, pick);
            random_bits(32, data);
            if (pick[0]) begin
                e = {1'b1, csr_word(12'h341, 5'd7, f3_rw), data, 32'h0, shadow_mepc,
                     1'b1, 1'b0, 32'h0, 1'b0};
                shadow_mepc = data;
            end else begin
                e = {1'b1, csr_word(12'h305, 5'd7, f3_rw), data, 32'h0, shadow_mtvec,
                     1'b1, 1'b0, 32'h0, 1'b0};
                shadow_mtvec = data;
            end
            apply_entry(e);
        end
        // final read-back of both
        e = {1'b1, csr_word(12'h305, 5'd0, f3_rs), 32'h0, 32'h0, shadow_mtvec,
             1'b1, 1'b0, 32'h0, 1'b0};
        apply_entry(e);
        e = {1'b1, csr_word(12'h341, 5'd0, f3_rs), 32'h0, 32'h0, shadow_mepc,
             1'b1, 1'b0, 32'h0, 1'b0};
        apply_entry(e);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* build.f */
logic/csr_pkg.sv
logic/csr_decode.sv
logic/csr_op_unit.sv
logic/csr_file.sv
logic/trap_unit.sv
logic/csr_unit_top.sv
testbench/csr_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the CSR block testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module csr_unit_tb -o csr_unit_sim
./obj_dir/csr_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
else
    exit 1
fi
